// File: src/rfStackPkg.sv
// rfStackPkg: widths, bank count and special register numbers for the banked register file
package rfStackPkg;

  // register file geometry
  localparam int unsigned DataWidth = 32;
  localparam int unsigned NumRegs = 32;
  localparam int unsigned NumLevels = 8;  // one bank per priority level

  localparam int unsigned RegsWidth = $clog2(NumRegs);
  localparam int unsigned LevelsWidth = $clog2(NumLevels);

  typedef logic [DataWidth-1:0] DataT;
  typedef logic [RegsWidth-1:0] AddrT;
  typedef logic [LevelsWidth-1:0] LevelT;
  typedef logic [NumLevels-1:0] IrqVecT;  // bit i requests level i, bit 0 unused

  localparam AddrT RegZero = AddrT'(0);  // x0, hardwired zero
  localparam AddrT RegRa = AddrT'(1);  // x1, gets the return marker
  localparam AddrT RegSp = AddrT'(2);  // x2, single copy in bank 0

  localparam DataT RaMarker = '1;  // written into ra on entry

endpackage

// File: src/irqArbiter.sv
// irqArbiter: picks the highest pending interrupt above the running level, registers an entry pulse
`timescale 1ns/100ps

module irqArbiter (
  input  logic               clk,
  input  logic               reset,
  input  rfStackPkg::IrqVecT irqPending,
  input  rfStackPkg::LevelT  level,
  input  logic               retEn,
  output logic               irqTaken,
  output rfStackPkg::LevelT  irqLevel
);

  rfStackPkg::LevelT topLevel;
  logic takeNow;

  // priority encoder, highest set line wins
  always_comb begin
    topLevel = '0;
    for (int i = 1; i < rfStackPkg::NumLevels; i++) begin
      if (irqPending[i]) begin
        topLevel = rfStackPkg::LevelT'(i);
      end
    end
  end

  // a return in the same cycle wins, the request waits
  // no pulse while the previous entry has not reached level yet
  always_comb begin
    takeNow = 1'b0;
    if (!retEn && !irqTaken) begin
      takeNow = (topLevel > level);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      irqTaken <= 1'b0;
    end else begin
      irqTaken <= takeNow;  // one cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (takeNow) begin
      irqLevel <= topLevel;  // held until the next entry
    end
  end

endmodule

// File: src/levelStack.sv
// levelStack: running priority level with a stack of preempted levels, push on entry, pop on return
`timescale 1ns/100ps

module levelStack (
  input  logic              clk,
  input  logic              reset,
  input  logic              irqTaken,
  input  rfStackPkg::LevelT irqLevel,
  input  logic              retEn,
  output rfStackPkg::LevelT level
);

  // levels rise strictly on push, so NumLevels entries never overflow
  rfStackPkg::LevelT stack [rfStackPkg::NumLevels];

  logic [rfStackPkg::LevelsWidth:0] depth;  // one extra bit for a full count
  rfStackPkg::LevelT pushIdx;
  rfStackPkg::LevelT popIdx;
  logic canPop;
  logic doPop;

  assign pushIdx = depth[rfStackPkg::LevelsWidth-1:0];
  assign popIdx = pushIdx - 1'b1;
  assign canPop = (depth != '0);

  // entry takes precedence if both strobes meet
  assign doPop = retEn && canPop && !irqTaken;

  always_ff @(posedge clk) begin
    if (reset) begin
      level <= '0;
      depth <= '0;
    end else if (irqTaken) begin
      level <= irqLevel;
      depth <= depth + 1'b1;
    end else if (doPop) begin
      level <= stack[popIdx];  // back to the preempted level
      depth <= depth - 1'b1;
    end
  end

  // return at level 0 with empty stack falls through, nothing changes

  always_ff @(posedge clk) begin
    if (irqTaken) begin
      stack[pushIdx] <= level;  // save the level being preempted
    end
  end

endmodule

// File: src/rfStack.sv
// rfStack: per-level register banks with shared sp, hardwired x0, ra marker write and write-through
`timescale 1ns/100ps

module rfStack (
  input  logic              clk,
  input  logic              reset,
  input  logic              writeEn,
  input  logic              writeRaEn,
  input  rfStackPkg::LevelT level,
  input  rfStackPkg::LevelT raLevel,
  input  rfStackPkg::AddrT  writeAddr,
  input  rfStackPkg::DataT  writeData,
  input  rfStackPkg::AddrT  readAddr1,
  input  rfStackPkg::AddrT  readAddr2,
  output rfStackPkg::DataT  readData1,
  output rfStackPkg::DataT  readData2
);

  rfStackPkg::DataT regs [rfStackPkg::NumLevels][rfStackPkg::NumRegs];

  logic userWrite;
  rfStackPkg::LevelT writeBank;

  assign userWrite = writeEn && (writeAddr != rfStackPkg::RegZero);  // x0 writes dropped
  assign writeBank = (writeAddr == rfStackPkg::RegSp) ? '0 : level;  // sp lives in bank 0

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < rfStackPkg::NumLevels; b++) begin
        for (int r = 0; r < rfStackPkg::NumRegs; r++) begin
          regs[b][r] <= '0;
        end
      end
    end else begin
      if (userWrite) begin
        regs[writeBank][writeAddr] <= writeData;
      end
      // marker goes into the bank being entered, never the running one
      if (writeRaEn) begin
        regs[raLevel][rfStackPkg::RegRa] <= rfStackPkg::RaMarker;
      end
    end
  end

  // read priority: x0, write-through, shared sp, current bank
  function automatic rfStackPkg::DataT readPort(input rfStackPkg::AddrT addr);
    rfStackPkg::DataT data;
    if (addr == rfStackPkg::RegZero) begin
      data = '0;
    end else if (writeEn && (addr == writeAddr)) begin
      data = writeData;
    end else if (addr == rfStackPkg::RegSp) begin
      data = regs[0][rfStackPkg::RegSp];
    end else begin
      data = regs[level][addr];
    end
    return data;
  endfunction

  always_comb begin
    readData1 = readPort(readAddr1);
  end

  always_comb begin
    readData2 = readPort(readAddr2);
  end

endmodule

// File: src/intRegFile.sv
// intRegFile: banked register file with interrupt arbitration and level stack for nested handlers
`timescale 1ns/100ps

module intRegFile (
  input  logic               clk,
  input  logic               reset,
  input  rfStackPkg::IrqVecT irqPending,
  input  logic               retEn,
  input  logic               writeEn,
  input  rfStackPkg::AddrT   writeAddr,
  input  rfStackPkg::DataT   writeData,
  input  rfStackPkg::AddrT   readAddr1,
  input  rfStackPkg::AddrT   readAddr2,
  output rfStackPkg::DataT   readData1,
  output rfStackPkg::DataT   readData2,
  output rfStackPkg::LevelT  level,
  output logic               irqTaken
);

  rfStackPkg::LevelT irqLevel;  // level chosen by the arbiter

  irqArbiter arb0 (
    .clk       (clk),
    .reset     (reset),
    .irqPending(irqPending),
    .level     (level),
    .retEn     (retEn),
    .irqTaken  (irqTaken),
    .irqLevel  (irqLevel)
  );

  levelStack stack0 (
    .clk     (clk),
    .reset   (reset),
    .irqTaken(irqTaken),
    .irqLevel(irqLevel),
    .retEn   (retEn),
    .level   (level)
  );

  // entry pulse doubles as the ra marker strobe
  rfStack rf0 (
    .clk      (clk),
    .reset    (reset),
    .writeEn  (writeEn),
    .writeRaEn(irqTaken),
    .level    (level),
    .raLevel  (irqLevel),
    .writeAddr(writeAddr),
    .writeData(writeData),
    .readAddr1(readAddr1),
    .readAddr2(readAddr2),
    .readData1(readData1),
    .readData2(readData2)
  );

endmodule

// File: dv/intRegFileAsserts.sv
// intRegFileAsserts: concurrent checks on entry pulses, level changes and x0 reads
`timescale 1ns/100ps

module intRegFileAsserts (
  input logic              clk,
  input logic              reset,
  input logic              irqTaken,
  input rfStackPkg::LevelT irqLevel,
  input rfStackPkg::LevelT level,
  input logic              retEn,
  input rfStackPkg::AddrT  readAddr1,
  input rfStackPkg::AddrT  readAddr2,
  input rfStackPkg::DataT  readData1,
  input rfStackPkg::DataT  readData2
);

  int assertFails = 0;  // failed assertion count

  property noBackToBack;
    @(posedge clk) disable iff (reset) irqTaken |=> !irqTaken;
  endproperty

  // entry only goes upward, new level lands one cycle later
  property entryRaises;
    @(posedge clk) disable iff (reset) irqTaken |-> (irqLevel > level);
  endproperty

  property entryLands;
    @(posedge clk) disable iff (reset) irqTaken |=> (level == $past(irqLevel));
  endproperty

  property levelMovesOnStrobe;
    @(posedge clk) disable iff (reset) !$stable(level) |-> ($past(irqTaken) || $past(retEn));
  endproperty

  property zeroReg1;
    @(posedge clk) disable iff (reset) (readAddr1 == rfStackPkg::RegZero) |-> (readData1 == '0);
  endproperty

  property zeroReg2;
    @(posedge clk) disable iff (reset) (readAddr2 == rfStackPkg::RegZero) |-> (readData2 == '0);
  endproperty

  noBackToBackA: assert property (noBackToBack) else begin
    $error("irqTaken high in two consecutive cycles");
    assertFails++;
  end

  entryRaisesA: assert property (entryRaises) else begin
    $error("irqTaken with irqLevel %0d not above level %0d", irqLevel, level);
    assertFails++;
  end

  entryLandsA: assert property (entryLands) else begin
    $error("level %0d after irqTaken does not match the chosen irqLevel", level);
    assertFails++;
  end

  levelMovesOnStrobeA: assert property (levelMovesOnStrobe) else begin
    $error("level changed to %0d without irqTaken or retEn", level);
    assertFails++;
  end

  zeroReg1A: assert property (zeroReg1) else begin
    $error("x0 read on port 1 returned %h", readData1);
    assertFails++;
  end

  zeroReg2A: assert property (zeroReg2) else begin
    $error("x0 read on port 2 returned %h", readData2);
    assertFails++;
  end

endmodule

// File: dv/intRegFileTb.sv
// intRegFileTb checks the banked register file with nested interrupt levels
`timescale 1ns/100ps

module intRegFileTb;

  localparam int TakeTimeout = 8;  // cycles to wait for irqTaken
  // about five times the 390 cycles the tests need
  localparam int WatchdogCycles = 2000;

  logic clk;
  logic reset;
  rfStackPkg::IrqVecT irqPending;
  logic retEn;
  logic writeEn;
  rfStackPkg::AddrT writeAddr;
  rfStackPkg::DataT writeData;
  rfStackPkg::AddrT readAddr1;
  rfStackPkg::AddrT readAddr2;
  rfStackPkg::DataT readData1;
  rfStackPkg::DataT readData2;
  rfStackPkg::LevelT level;
  logic irqTaken;

  // reference model of banks, running level and preempted levels
  rfStackPkg::DataT model [rfStackPkg::NumLevels][rfStackPkg::NumRegs];
  rfStackPkg::LevelT refLevel;
  rfStackPkg::LevelT refStack [$];

  string testName;
  int testChecks;
  int testFails;
  int totalChecks;
  int totalFails;
  int boundFails;
  integer seed;

  intRegFile dut0 (
    .clk       (clk),
    .reset     (reset),
    .irqPending(irqPending),
    .retEn     (retEn),
    .writeEn   (writeEn),
    .writeAddr (writeAddr),
    .writeData (writeData),
    .readAddr1 (readAddr1),
    .readAddr2 (readAddr2),
    .readData1 (readData1),
    .readData2 (readData2),
    .level     (level),
    .irqTaken  (irqTaken)
  );

  bind intRegFile intRegFileAsserts asserts0 (
    .clk      (clk),
    .reset    (reset),
    .irqTaken (irqTaken),
    .irqLevel (irqLevel),
    .level    (level),
    .retEn    (retEn),
    .readAddr1(readAddr1),
    .readAddr2(readAddr2),
    .readData1(readData1),
    .readData2(readData2)
  );

  always #20 clk = ~clk;

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    testChecks++;
    assert (actual === expected) else begin
      $display("mismatch %s %s: expected %h, actual %h", testName, what, expected, actual);
      testFails++;
    end
  endtask

  task automatic finishTest();
    $display("test %s done: %0d checks, %0d errors", testName, testChecks, testFails);
    totalChecks += testChecks;
    totalFails += testFails;
    testChecks = 0;
    testFails = 0;
  endtask

  task automatic clearModel();
    for (int b = 0; b < rfStackPkg::NumLevels; b++) begin
      for (int r = 0; r < rfStackPkg::NumRegs; r++) begin
        model[b][r] = '0;
      end
    end
    refLevel = '0;
    refStack.delete();
  endtask

  function automatic rfStackPkg::DataT expectRead(input rfStackPkg::AddrT addr);
    rfStackPkg::DataT data;
    if (addr == rfStackPkg::RegZero) begin
      data = '0;
    end else if (addr == rfStackPkg::RegSp) begin
      data = model[0][rfStackPkg::RegSp];  // one sp for all levels
    end else begin
      data = model[refLevel][addr];
    end
    return data;
  endfunction

  task automatic writeReg(input rfStackPkg::AddrT addr, input rfStackPkg::DataT data);
    rfStackPkg::LevelT bank;
    rfStackPkg::DataT expected;
    @(negedge clk);
    writeEn = 1'b1;
    writeAddr = addr;
    writeData = data;
    readAddr1 = addr;
    readAddr2 = addr;
    expected = (addr == rfStackPkg::RegZero) ? rfStackPkg::DataT'(0) : data;
    #5;
    checkValue($sformatf("write-through x%0d port 1", addr), expected, readData1);
    checkValue($sformatf("write-through x%0d port 2", addr), expected, readData2);
    if (addr != rfStackPkg::RegZero) begin
      bank = (addr == rfStackPkg::RegSp) ? rfStackPkg::LevelT'(0) : refLevel;
      model[bank][addr] = data;
    end
    @(negedge clk);
    writeEn = 1'b0;
  endtask

  task automatic fillRegs(input int first, input int last);
    rfStackPkg::DataT data;
    for (int r = first; r <= last; r++) begin
      data = $random(seed);
      writeReg(rfStackPkg::AddrT'(r), data);
    end
  endtask

  // walks all registers of the running bank on both ports
  task automatic checkBank();
    for (int r = 0; r < rfStackPkg::NumRegs; r++) begin
      @(negedge clk);
      readAddr1 = rfStackPkg::AddrT'(r);
      readAddr2 = rfStackPkg::AddrT'(rfStackPkg::NumRegs - 1 - r);
      #5;
      checkValue($sformatf("L%0d x%0d port 1", refLevel, readAddr1),
                 expectRead(readAddr1), readData1);
      checkValue($sformatf("L%0d x%0d port 2", refLevel, readAddr2),
                 expectRead(readAddr2), readData2);
    end
  endtask

  task automatic awaitEntry(input int line);
    int waited;
    logic seen;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < TakeTimeout) begin
      @(negedge clk);
      #5;
      seen = irqTaken;
      waited++;
    end
    if (!seen) begin
      $display("%s: irqTaken did not rise within %0d cycles for line %0d",
               testName, TakeTimeout, line);
      testFails++;
    end else begin
      checkValue("level before entry lands", refLevel, level);
      refStack.push_back(refLevel);
      refLevel = rfStackPkg::LevelT'(line);
      model[line][rfStackPkg::RegRa] = rfStackPkg::RaMarker;
    end
    @(negedge clk);
    irqPending[line] = 1'b0;  // serviced
    readAddr1 = rfStackPkg::RegRa;
    readAddr2 = rfStackPkg::RegZero;
    #5;
    if (seen) begin
      checkValue("single irqTaken pulse", 0, irqTaken);
      checkValue("level after entry", refLevel, level);
      checkValue("ra marker", rfStackPkg::RaMarker, readData1);
    end
  endtask

  task automatic enterLevel(input int line);
    @(negedge clk);
    irqPending[line] = 1'b1;
    awaitEntry(line);
  endtask

  task automatic returnLevel();
    @(negedge clk);
    retEn = 1'b1;
    @(negedge clk);
    retEn = 1'b0;
    if (refStack.size() > 0) begin
      refLevel = refStack.pop_back();
    end
    #5;
    checkValue("level after return", refLevel, level);
  endtask

  task automatic afterReset();
    rfStackPkg::DataT data;
    testName = "reset";
    data = $random(seed);
    @(negedge clk);
    #5;
    checkValue("level", 0, level);
    checkValue("irqTaken", 0, irqTaken);
    checkBank();
    writeReg(rfStackPkg::RegZero, data);
    @(negedge clk);
    readAddr1 = rfStackPkg::RegZero;
    readAddr2 = rfStackPkg::RegZero;
    #5;
    checkValue("x0 after write port 1", 0, readData1);
    checkValue("x0 after write port 2", 0, readData2);
    finishTest();
  endtask

  task automatic bankingAndBypass();
    testName = "banking";
    fillRegs(1, 12);  // includes ra and sp
    checkBank();
    enterLevel(1);
    checkBank();
    returnLevel();
    checkBank();
    finishTest();
  endtask

  task automatic singleEntry();
    testName = "entry";
    enterLevel(3);
    @(negedge clk);
    irqPending[2] = 1'b1;
    irqPending[3] = 1'b1;
    repeat (4) begin
      @(negedge clk);
      #5;
      checkValue("no entry at or below level", 0, irqTaken);
    end
    @(negedge clk);
    irqPending = '0;
    #5;
    checkValue("level held", refLevel, level);
    checkBank();
    returnLevel();
    finishTest();
  endtask

  task automatic nestedReturn();
    rfStackPkg::DataT data;
    testName = "nesting";
    enterLevel(2);
    fillRegs(5, 8);
    enterLevel(5);
    fillRegs(5, 8);
    data = $random(seed);
    writeReg(rfStackPkg::RegSp, data);  // lands in bank 0
    checkBank();
    returnLevel();
    checkBank();
    returnLevel();
    checkBank();
    returnLevel();  // empty stack so level stays 0
    finishTest();
  endtask

  task automatic returnBeatsEntry();
    testName = "coincidence";
    enterLevel(2);
    @(negedge clk);
    retEn = 1'b1;
    irqPending[3] = 1'b1;
    @(negedge clk);
    retEn = 1'b0;
    refLevel = refStack.pop_back();
    #5;
    checkValue("no entry with return", 0, irqTaken);
    checkValue("return first", refLevel, level);
    awaitEntry(3);  // request still pending
    checkBank();
    returnLevel();
    finishTest();
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    irqPending = '0;
    retEn = 1'b0;
    writeEn = 1'b0;
    writeAddr = '0;
    writeData = '0;
    readAddr1 = '0;
    readAddr2 = '0;
    seed = 32'hf2c8d887;
    testChecks = 0;
    testFails = 0;
    totalChecks = 0;
    totalFails = 0;
    clearModel();
    repeat (16) @(negedge clk);
    reset = 1'b0;

    afterReset();
    bankingAndBypass();
    singleEntry();
    nestedReturn();
    returnBeatsEntry();

    boundFails = dut0.asserts0.assertFails;
    $display("checks passed %0d, failed %0d, assertion failures %0d",
             totalChecks - totalFails, totalFails, boundFails);
    if (totalFails == 0 && boundFails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: intRegFile.f
src/rfStackPkg.sv
src/irqArbiter.sv
src/levelStack.sv
src/rfStack.sv
src/intRegFile.sv
dv/intRegFileAsserts.sv
dv/intRegFileTb.sv
